//--- hdl/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath width
`define OOO_XLEN       32

// architectural register file
`define OOO_NREGS      32
`define OOO_REG_IDX_W  5

// rob size, tag must index every entry
`define OOO_ROB_DEPTH  8
`define OOO_TAG_W      3

// reservation station entries
`define OOO_RS_DEPTH   4

`endif

//--- hdl/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]      word_t;
    typedef logic [`OOO_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`OOO_TAG_W-1:0]     rob_tag_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sll,
        op_srl
    } alu_op_t;

    // decoded instruction at the issue port
    typedef struct packed {
        alu_op_t  op;
        logic     use_imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } issue_t;

    // one source operand as read at issue
    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        word_t    value;
    } commit_t;

    // rs to alu
    typedef struct packed {
        rob_tag_t tag;
        alu_op_t  op;
        word_t    a;
        word_t    b;
    } dispatch_t;

endpackage

//--- hdl/reg_rename_file.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reg_rename_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_fire,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    input  ooo_pkg::reg_idx_t rd,
    input  ooo_pkg::rob_tag_t issue_tag,
    input  logic              commit_valid,
    input  ooo_pkg::commit_t  commit,
    output ooo_pkg::operand_t src1,
    output ooo_pkg::operand_t src2
);
    import ooo_pkg::*;

    word_t                  regs [`OOO_NREGS];
    rob_tag_t               tags [`OOO_NREGS];
    logic [`OOO_NREGS-1:0]  busy;

    // r0 is never marked busy and never written, so it reads zero
    always_comb begin
        src1.busy  = busy[rs1];
        src1.tag   = tags[rs1];
        src1.value = regs[rs1];
        src2.busy  = busy[rs2];
        src2.tag   = tags[rs2];
        src2.value = regs[rs2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NREGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (commit_valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                // only the newest writer releases the register
                if (tags[commit.rd] == commit.tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            // issue comes last so a same-cycle rename keeps rd busy
            if (issue_fire && rd != '0) begin
                busy[rd] <= 1'b1;
                tags[rd] <= issue_tag;
            end
        end
    end

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_fire,
    input  ooo_pkg::reg_idx_t issue_rd,
    output ooo_pkg::rob_tag_t tail_tag,
    output logic              full,
    input  ooo_pkg::rob_tag_t lookup_tag1,
    input  ooo_pkg::rob_tag_t lookup_tag2,
    output logic              lookup_done1,
    output logic              lookup_done2,
    output ooo_pkg::word_t    lookup_val1,
    output ooo_pkg::word_t    lookup_val2,
    input  ooo_pkg::cdb_t     cdb,
    output logic              commit_valid,
    output ooo_pkg::commit_t  commit
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH + 1);

    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [CNT_W-1:0]          count;
    logic [`OOO_ROB_DEPTH-1:0] done;
    reg_idx_t                  rd_q  [`OOO_ROB_DEPTH];
    word_t                     val_q [`OOO_ROB_DEPTH];

    assign tail_tag = tail;
    assign full     = (count == CNT_W'(`OOO_ROB_DEPTH));

    // operand lookups for sources still renamed to an rob entry
    assign lookup_done1 = done[lookup_tag1];
    assign lookup_done2 = done[lookup_tag2];
    assign lookup_val1  = val_q[lookup_tag1];
    assign lookup_val2  = val_q[lookup_tag2];

    // head retires as soon as its result is in
    assign commit_valid = (count != '0) && done[head];

    always_comb begin
        commit.rd    = rd_q[head];
        commit.tag   = head;
        commit.value = val_q[head];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (issue_fire) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            case ({issue_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            rd_q[tail] <= issue_rd;
        end
        if (cdb.valid) begin
            val_q[cdb.tag] <= cdb.value;
        end
    end

endmodule

//--- hdl/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_fire,
    input  ooo_pkg::issue_t    issue,
    input  ooo_pkg::rob_tag_t  issue_tag,
    input  ooo_pkg::operand_t  src1,
    input  ooo_pkg::operand_t  src2,
    input  logic               rob_done1,
    input  logic               rob_done2,
    input  ooo_pkg::word_t     rob_val1,
    input  ooo_pkg::word_t     rob_val2,
    input  ooo_pkg::cdb_t      cdb,
    output logic               full,
    output logic               disp_valid,
    output ooo_pkg::dispatch_t disp
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    logic [`OOO_RS_DEPTH-1:0] valid;
    logic [`OOO_RS_DEPTH-1:0] rdy_a;
    logic [`OOO_RS_DEPTH-1:0] rdy_b;
    alu_op_t                  op    [`OOO_RS_DEPTH];
    rob_tag_t                 dest  [`OOO_RS_DEPTH];
    rob_tag_t                 tag_a [`OOO_RS_DEPTH];
    rob_tag_t                 tag_b [`OOO_RS_DEPTH];
    word_t                    val_a [`OOO_RS_DEPTH];
    word_t                    val_b [`OOO_RS_DEPTH];
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         disp_idx;
    logic                     new_rdy_a;
    logic                     new_rdy_b;
    word_t                    new_val_a;
    word_t                    new_val_b;

    // resolve sources: register, then finished rob entry, then cdb bypass
    always_comb begin
        new_rdy_a = 1'b1;
        new_val_a = src1.value;
        if (src1.busy) begin
            if (rob_done1) begin
                new_val_a = rob_val1;
            end else if (cdb.valid && cdb.tag == src1.tag) begin
                new_val_a = cdb.value;
            end else begin
                new_rdy_a = 1'b0;
            end
        end
        new_rdy_b = 1'b1;
        new_val_b = src2.value;
        if (issue.use_imm) begin
            new_val_b = issue.imm;
        end else if (src2.busy) begin
            if (rob_done2) begin
                new_val_b = rob_val2;
            end else if (cdb.valid && cdb.tag == src2.tag) begin
                new_val_b = cdb.value;
            end else begin
                new_rdy_b = 1'b0;
            end
        end
    end

    // lowest free slot and lowest ready entry
    always_comb begin
        free_idx = '0;
        disp_idx = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (valid[i] && rdy_a[i] && rdy_b[i]) begin
                disp_idx = IDX_W'(i);
            end
        end
    end

    assign full       = &valid;
    assign disp_valid = |(valid & rdy_a & rdy_b);

    always_comb begin
        disp.tag = dest[disp_idx];
        disp.op  = op[disp_idx];
        disp.a   = val_a[disp_idx];
        disp.b   = val_b[disp_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            rdy_a <= '0;
            rdy_b <= '0;
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (valid[i] && cdb.valid && !rdy_a[i] && cdb.tag == tag_a[i]) begin
                    rdy_a[i] <= 1'b1;
                end
                if (valid[i] && cdb.valid && !rdy_b[i] && cdb.tag == tag_b[i]) begin
                    rdy_b[i] <= 1'b1;
                end
            end
            if (disp_valid) begin
                valid[disp_idx] <= 1'b0;
            end
            if (issue_fire) begin
                valid[free_idx] <= 1'b1;
                rdy_a[free_idx] <= new_rdy_a;
                rdy_b[free_idx] <= new_rdy_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (valid[i] && cdb.valid && !rdy_a[i] && cdb.tag == tag_a[i]) begin
                val_a[i] <= cdb.value;
            end
            if (valid[i] && cdb.valid && !rdy_b[i] && cdb.tag == tag_b[i]) begin
                val_b[i] <= cdb.value;
            end
        end
        if (issue_fire) begin
            op[free_idx]    <= issue.op;
            dest[free_idx]  <= issue_tag;
            tag_a[free_idx] <= src1.tag;
            tag_b[free_idx] <= src2.tag;
            val_a[free_idx] <= new_val_a;
            val_b[free_idx] <= new_val_b;
        end
    end

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  ooo_pkg::dispatch_t disp,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    word_t result;
    logic  less;

    assign less = $signed(disp.a) < $signed(disp.b);

    always_comb begin
        case (disp.op)
            op_add:  result = disp.a + disp.b;
            op_sub:  result = disp.a - disp.b;
            op_and:  result = disp.a & disp.b;
            op_or:   result = disp.a | disp.b;
            op_xor:  result = disp.a ^ disp.b;
            op_slt:  result = word_t'(less);
            // shift amount is the low 5 bits of b
            op_sll:  result = disp.a << disp.b[4:0];
            op_srl:  result = disp.a >> disp.b[4:0];
            default: result = '0;
        endcase
    end

    // single stage straight onto the cdb
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= disp_valid;
        end
        cdb.tag   <= disp.tag;
        cdb.value <= result;
    end

endmodule

//--- hdl/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  ooo_pkg::issue_t  issue,
    output logic             issue_stall,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    logic      issue_fire;
    logic      rob_full;
    logic      rs_full;
    operand_t  src1;
    operand_t  src2;
    rob_tag_t  tail_tag;
    logic      rob_done1;
    logic      rob_done2;
    word_t     rob_val1;
    word_t     rob_val2;
    cdb_t      cdb;
    logic      disp_valid;
    dispatch_t disp;

    // stall whenever either rob or rs has no room
    assign issue_stall = rob_full | rs_full;
    assign issue_fire  = issue_valid & ~issue_stall;

    reg_rename_file rename0 (
        .clk          (clk),
        .rst          (rst),
        .issue_fire   (issue_fire),
        .rs1          (issue.rs1),
        .rs2          (issue.rs2),
        .rd           (issue.rd),
        .issue_tag    (tail_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .src1         (src1),
        .src2         (src2)
    );

    reorder_buffer rob0 (
        .clk          (clk),
        .rst          (rst),
        .issue_fire   (issue_fire),
        .issue_rd     (issue.rd),
        .tail_tag     (tail_tag),
        .full         (rob_full),
        .lookup_tag1  (src1.tag),
        .lookup_tag2  (src2.tag),
        .lookup_done1 (rob_done1),
        .lookup_done2 (rob_done2),
        .lookup_val1  (rob_val1),
        .lookup_val2  (rob_val2),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    reservation_station rs0 (
        .clk        (clk),
        .rst        (rst),
        .issue_fire (issue_fire),
        .issue      (issue),
        .issue_tag  (tail_tag),
        .src1       (src1),
        .src2       (src2),
        .rob_done1  (rob_done1),
        .rob_done2  (rob_done2),
        .rob_val1   (rob_val1),
        .rob_val2   (rob_val2),
        .cdb        (cdb),
        .full       (rs_full),
        .disp_valid (disp_valid),
        .disp       (disp)
    );

    alu_unit alu0 (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp       (disp),
        .cdb        (cdb)
    );

endmodule

//--- tb/ooo_core_sva.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_sva (
    input logic              clk,
    input logic              rst,
    input logic              issue_valid,
    input logic              issue_stall,
    input logic              commit_valid,
    input ooo_pkg::rob_tag_t commit_tag,
    input logic              disp_valid,
    input logic              rob_full,
    input logic              rs_full
);
    import ooo_pkg::*;

    // tag the next commit must carry
    rob_tag_t next_tag;
    // occupancy rebuilt from the handshakes
    int       rob_cnt;
    int       rs_cnt;
    int       fail_count = 0;
    logic     fire;

    assign fire = issue_valid && !issue_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
            rob_cnt  <= 0;
            rs_cnt   <= 0;
        end else begin
            if (commit_valid) begin
                next_tag <= commit_tag + 1'b1;
            end
            rob_cnt <= rob_cnt + (fire ? 1 : 0) - (commit_valid ? 1 : 0);
            rs_cnt  <= rs_cnt + (fire ? 1 : 0) - (disp_valid ? 1 : 0);
        end
    end

    // state is cleared one edge into reset
    assert property (@(posedge clk) rst |=> !commit_valid)
        else begin
            $error("commit_valid high during reset");
            fail_count++;
        end

    // 3-bit tag wraps at the rob depth
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> commit_tag == next_tag)
        else begin
            $error("commit tag out of order");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     (rob_cnt < `OOO_ROB_DEPTH && rs_cnt < `OOO_RS_DEPTH) |-> !issue_stall)
        else begin
            $error("issue_stall high with room in rob and rs");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     rob_full == (rob_cnt == `OOO_ROB_DEPTH) &&
                     rs_full == (rs_cnt == `OOO_RS_DEPTH))
        else begin
            $error("full flags disagree with rob or rs occupancy");
            fail_count++;
        end

endmodule

bind ooo_core ooo_core_sva sva0 (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_stall  (issue_stall),
    .commit_valid (commit_valid),
    .commit_tag   (commit.tag),
    .disp_valid   (disp_valid),
    .rob_full     (rob_full),
    .rs_full      (rs_full)
);

//--- tb/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int N_RAND  = 24;

    logic    clk = 1'b0;
    logic    rst;
    logic    issue_valid;
    issue_t  issue;
    logic    issue_stall;
    logic    commit_valid;
    commit_t commit;

    // stimulus table in program order
    string   names   [$];
    issue_t  rows    [$];
    word_t   exp_val [$];
    int      gaps    [$];
    int      errors;
    int      timeouts;

    ooo_core dut0 (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_stall  (issue_stall),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #10 clk = ~clk;

    task automatic add_row(input string name, input alu_op_t op, input logic use_imm,
                           input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                           input word_t imm);
        issue_t ins;
        ins.op      = op;
        ins.use_imm = use_imm;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.rs2     = rs2;
        ins.imm     = imm;
        names.push_back(name);
        rows.push_back(ins);
    endtask

    // reference alu per operation
    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function automatic string commit_str(reg_idx_t rd, rob_tag_t tag, word_t value);
        return $sformatf("rd=%0d tag=%0d value=%08h", rd, tag, value);
    endfunction

    task automatic build_table;
        add_row("li_r1", op_add, 1'b1, 5'd1, 5'd0, 5'd0, 32'h0000_1234);
        add_row("li_r2", op_add, 1'b1, 5'd2, 5'd0, 5'd0, 32'hffff_fffb);
        add_row("li_r3", op_add, 1'b1, 5'd3, 5'd0, 5'd0, 32'd7);
        add_row("add", op_add, 1'b0, 5'd4, 5'd1, 5'd2, '0);
        add_row("sub", op_sub, 1'b0, 5'd5, 5'd1, 5'd2, '0);
        add_row("and", op_and, 1'b0, 5'd6, 5'd1, 5'd2, '0);
        add_row("or", op_or, 1'b0, 5'd7, 5'd1, 5'd2, '0);
        add_row("xor", op_xor, 1'b0, 5'd8, 5'd1, 5'd2, '0);
        add_row("slt_neg", op_slt, 1'b0, 5'd9, 5'd2, 5'd1, '0);
        add_row("slt_pos", op_slt, 1'b0, 5'd10, 5'd1, 5'd2, '0);
        add_row("sll", op_sll, 1'b0, 5'd11, 5'd1, 5'd3, '0);
        add_row("srl", op_srl, 1'b0, 5'd12, 5'd2, 5'd3, '0);
        add_row("subi", op_sub, 1'b1, 5'd4, 5'd1, 5'd0, 32'h34);
        add_row("andi", op_and, 1'b1, 5'd5, 5'd2, 5'd0, 32'h0ff0);
        add_row("ori", op_or, 1'b1, 5'd6, 5'd1, 5'd0, 32'hf000_0000);
        add_row("xori", op_xor, 1'b1, 5'd7, 5'd2, 5'd0, 32'h5555_5555);
        add_row("slti", op_slt, 1'b1, 5'd8, 5'd2, 5'd0, 32'hffff_fff0);
        add_row("slli", op_sll, 1'b1, 5'd9, 5'd1, 5'd0, 32'd36);
        add_row("srli", op_srl, 1'b1, 5'd10, 5'd2, 5'd0, 32'd28);
        // back to back dependent chain
        add_row("raw1", op_add, 1'b1, 5'd13, 5'd1, 5'd0, 32'd1);
        add_row("raw2", op_add, 1'b0, 5'd13, 5'd13, 5'd13, '0);
        add_row("raw3", op_sub, 1'b0, 5'd14, 5'd13, 5'd1, '0);
        add_row("raw4", op_xor, 1'b0, 5'd15, 5'd14, 5'd13, '0);
        add_row("raw5", op_sll, 1'b0, 5'd15, 5'd15, 5'd3, '0);
        add_row("waw1", op_add, 1'b1, 5'd16, 5'd0, 5'd0, 32'd10);
        add_row("waw2", op_add, 1'b1, 5'd16, 5'd0, 5'd0, 32'd20);
        add_row("waw_rd", op_add, 1'b0, 5'd17, 5'd16, 5'd0, '0);
        add_row("r0_write", op_add, 1'b1, 5'd0, 5'd1, 5'd0, 32'd99);
        add_row("r0_read", op_add, 1'b0, 5'd18, 5'd0, 5'd0, '0);
        add_row("r0_imm", op_or, 1'b1, 5'd19, 5'd0, 5'd0, 32'd5);
        // small register window so random rows depend on each other
        for (int k = 0; k < N_RAND; k++) begin
            add_row($sformatf("rand_%0d", k), alu_op_t'($urandom % 8), $urandom % 2,
                    reg_idx_t'($urandom % 8), reg_idx_t'($urandom % 8),
                    reg_idx_t'($urandom % 8), $urandom);
        end
        // mostly dense with an occasional pause
        foreach (rows[i]) begin
            gaps.push_back(($urandom % 4 == 0) ? int'($urandom % 4) : 0);
        end
    endtask

    // in-order model over the whole table
    task automatic fill_expected;
        word_t regs [`OOO_NREGS];
        word_t a;
        word_t b;
        word_t r;
        for (int k = 0; k < `OOO_NREGS; k++) begin
            regs[k] = '0;
        end
        foreach (rows[i]) begin
            a = regs[rows[i].rs1];
            b = rows[i].use_imm ? rows[i].imm : regs[rows[i].rs2];
            r = model_alu(rows[i].op, a, b);
            exp_val.push_back(r);
            if (rows[i].rd != '0) begin
                regs[rows[i].rd] = r;
            end
        end
    endtask

    task automatic drive_rows;
        int waited;
        for (int i = 0; i < rows.size(); i++) begin
            if (gaps[i] > 0) begin
                issue_valid <= 1'b0;
                repeat (gaps[i]) @(posedge clk);
            end
            issue_valid <= 1'b1;
            issue       <= rows[i];
            // stall only moves on a rising edge
            waited = 0;
            @(negedge clk);
            while (issue_stall && waited < TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (issue_stall) begin
                $display("issue of %s still stalled after %0d cycles", names[i], TIMEOUT);
                timeouts++;
                break;
            end
            @(posedge clk);
        end
        issue_valid <= 1'b0;
    endtask

    task automatic check_commits;
        int waited;
        for (int j = 0; j < rows.size(); j++) begin
            waited = 0;
            @(negedge clk);
            while (!commit_valid && waited < TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!commit_valid) begin
                $display("no commit for %s within %0d cycles", names[j], TIMEOUT);
                timeouts++;
                return;
            end
            // tags are handed out in program order from zero
            if (commit.rd !== rows[j].rd || commit.tag !== rob_tag_t'(j) ||
                    commit.value !== exp_val[j]) begin
                $display("ERROR %s: expected %s, actual %s", names[j],
                         commit_str(rows[j].rd, rob_tag_t'(j), exp_val[j]),
                         commit_str(commit.rd, commit.tag, commit.value));
                errors++;
            end
        end
        // nothing else may retire once the table is drained
        repeat (20) begin
            @(negedge clk);
            if (commit_valid) begin
                $display("extra commit of rd=%0d after the last instruction", commit.rd);
                errors++;
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        errors      = 0;
        timeouts    = 0;
        void'($urandom(32'h45bf_85d6));
        build_table();
        fill_expected();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fork
            drive_rows();
            check_commits();
        join
        $display("rows: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 rows.size(), errors, timeouts, dut0.sva0.fail_count);
        if (errors == 0 && timeouts == 0 && dut0.sva0.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- ooo_core.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/reg_rename_file.sv
hdl/reorder_buffer.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/ooo_core.sv
tb/ooo_core_sva.sv
tb/ooo_core_tb.sv
